// File: logic/dispatch_pkg.sv
package dispatch_pkg;

  // cpu bus and memory bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // cpu message channel width
  localparam int MSG_W = 8;

  // slot table geometry
  // CPU_COUNT is expected to be 2**SLOT_W
  localparam int CPU_COUNT = 4;
  localparam int SLOT_W = 2;

  // messages a polled cpu sends together with ext_cpu_e
  localparam logic [MSG_W-1:0] MSG_NONE = 8'h00;
  // claim a free slot, addr_in carries the process address
  localparam logic [MSG_W-1:0] MSG_START = 8'h01;
  // give the polled slot back
  localparam logic [MSG_W-1:0] MSG_END = 8'h02;

  // cpu index presented with ext_cpu_q
  // all zero means nobody is addressed
  typedef struct packed {
    // names a running cpu, num is its slot
    logic active;
    // offer to any idle cpu, num unused
    logic nonactive;
    logic [SLOT_W-1:0] num;
  } cpu_index_t;

  // one latched cpu memory request
  typedef struct packed {
    logic read;
    logic write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } mem_req_t;

  // what the external memory handed back at done
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } mem_rsp_t;

  // dispatcher main fsm
  typedef enum logic [1:0] {
    // cpus held in reset
    RESET_WAIT,
    // pick who gets the next turn
    CPU_LOOP,
    // wait for the addressed cpu
    CPU_CMD,
    // relay busy with external memory
    MEM_WORK
  } ctl_state_t;

endpackage

// File: logic/cpu_slot.sv
`timescale 1ns/1ps

// one entry of the cpu table
module cpu_slot
  import dispatch_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              set,
  input  logic              clear,
  input  logic [ADDR_W-1:0] set_addr,
  output logic              active,
  output logic [ADDR_W-1:0] proc_addr
);

  // occupancy flag
  // set wins, though the fsm never raises both
  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
    end else if (set) begin
      active <= 1'b1;
    end else if (clear) begin
      active <= 1'b0;
    end
  end

  // process address given at start
  // only meaningful while active is high
  always_ff @(posedge clk) begin
    if (set) begin
      proc_addr <= set_addr;
    end
  end

  // start and end come from different turns
  // so one slot never sees both strobes at once
  a_no_set_and_clear: assert property (
    @(posedge clk) disable iff (rst)
    !(set && clear)
  );

  // a slot is only claimed while it is free
  a_set_only_when_free: assert property (
    @(posedge clk) disable iff (rst)
    set |-> !active
  );

endmodule

// File: logic/slot_picker.sv
`timescale 1ns/1ps

// reduces the slot flags to the two answers the fsm needs
module slot_picker
  import dispatch_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [CPU_COUNT-1:0] slot_active,
  input  logic                 advance,
  output logic [SLOT_W-1:0]    free_slot,
  output logic                 any_free,
  output logic [SLOT_W-1:0]    next_active,
  output logic                 any_active
);

  // slot polled last
  logic [SLOT_W-1:0] last_ptr;

  // lowest inactive slot
  // walk downwards so the smallest index is written last
  always_comb begin
    free_slot = '0;
    any_free = 1'b0;
    for (int i = CPU_COUNT - 1; i >= 0; i--) begin
      if (!slot_active[i]) begin
        free_slot = SLOT_W'(i);
        any_free = 1'b1;
      end
    end
  end

  // somebody is running
  assign any_active = |slot_active;

  // first active slot after last_ptr with wrap to 0
  // largest step first so the nearest one survives
  always_comb begin
    int idx;
    next_active = '0;
    for (int step = CPU_COUNT; step >= 1; step--) begin
      idx = (int'(last_ptr) + step) % CPU_COUNT;
      if (slot_active[idx]) begin
        next_active = SLOT_W'(idx);
      end
    end
  end

  // start just below slot 0 so the first poll lands on 0
  always_ff @(posedge clk) begin
    if (rst) begin
      last_ptr <= SLOT_W'(CPU_COUNT - 1);
    end else if (advance) begin
      last_ptr <= next_active;
    end
  end

  // the poll target must be a running cpu
  a_next_is_active: assert property (
    @(posedge clk) disable iff (rst)
    any_active |-> slot_active[next_active]
  );

endmodule

// File: logic/mem_relay.sv
`timescale 1ns/1ps

// carries one cpu read or write out to the external memory
module mem_relay
  import dispatch_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  mem_req_t          req,
  input  logic              req_valid,
  input  logic              rw_halt,
  input  logic [ADDR_W-1:0] ext_mem_addr_in,
  input  logic [DATA_W-1:0] ext_mem_data_in,
  input  logic              ext_read_dn,
  input  logic              ext_write_dn,
  output logic              ext_read_q,
  output logic              ext_write_q,
  output logic              ext_rw_halt,
  output logic [ADDR_W-1:0] ext_mem_addr_out,
  output logic [DATA_W-1:0] ext_mem_data_out,
  output mem_rsp_t          rsp,
  output logic              read_dn,
  output logic              write_dn,
  output logic              bus_busy,
  output logic              relay_done,
  output logic              relay_aborted
);

  // latched request payload
  logic [ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0] data_q;
  // memory answered the pending access
  logic mem_done;

  assign mem_done = (ext_read_q && ext_read_dn) || (ext_write_q && ext_write_dn);

  always_ff @(posedge clk) begin
    if (rst) begin
      ext_read_q <= 1'b0;
      ext_write_q <= 1'b0;
      ext_rw_halt <= 1'b0;
      read_dn <= 1'b0;
      write_dn <= 1'b0;
      bus_busy <= 1'b0;
      rsp <= '0;
    end else begin
      // pulses and rsp drop back to zero outside the done cycle
      ext_rw_halt <= 1'b0;
      read_dn <= 1'b0;
      write_dn <= 1'b0;
      bus_busy <= 1'b0;
      rsp <= '0;
      if (rw_halt && (req_valid || ext_read_q || ext_write_q)) begin
        // abort beats a done arriving in the same cycle
        ext_read_q <= 1'b0;
        ext_write_q <= 1'b0;
        ext_rw_halt <= 1'b1;
      end else if (req_valid) begin
        ext_read_q <= req.read;
        ext_write_q <= req.write;
      end else if (mem_done) begin
        ext_read_q <= 1'b0;
        ext_write_q <= 1'b0;
        read_dn <= ext_read_q;
        write_dn <= ext_write_q;
        bus_busy <= 1'b1;
        rsp <= '{addr: ext_mem_addr_in, data: ext_mem_data_in};
      end
    end
  end

  // address and data stay put for the whole access
  always_ff @(posedge clk) begin
    if (req_valid) begin
      addr_q <= req.addr;
      data_q <= req.data;
    end
  end

  assign ext_mem_addr_out = addr_q;
  assign ext_mem_data_out = data_q;

  // back to the fsm
  assign relay_done = read_dn | write_dn;
  assign relay_aborted = ext_rw_halt;

  a_one_direction: assert property (
    @(posedge clk) disable iff (rst)
    !(ext_read_q && ext_write_q)
  );

endmodule

// File: logic/dispatch_ctl.sv
`timescale 1ns/1ps

// reset sequencing, turn selection and cpu command handling
module dispatch_ctl
  import dispatch_pkg::*;
(
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              ext_rst_e,
  input  logic                              read_q,
  input  logic                              write_q,
  input  logic                              ext_cpu_e,
  input  logic [MSG_W-1:0]                  cpu_msg_in,
  input  logic [ADDR_W-1:0]                 addr_in,
  input  logic [DATA_W-1:0]                 data_in,
  input  logic [CPU_COUNT-1:0]              slot_active,
  input  logic [CPU_COUNT-1:0][ADDR_W-1:0]  slot_addr,
  input  logic [SLOT_W-1:0]                 free_slot,
  input  logic                              any_free,
  input  logic [SLOT_W-1:0]                 next_active,
  input  logic                              any_active,
  input  logic                              relay_done,
  input  logic                              relay_aborted,
  output logic                              ext_rst_b,
  output logic                              ext_cpu_q,
  output cpu_index_t                        ext_cpu_index,
  output logic [ADDR_W-1:0]                 poll_addr,
  output logic [CPU_COUNT-1:0]              slot_set,
  output logic [CPU_COUNT-1:0]              slot_clear,
  output logic [ADDR_W-1:0]                 slot_set_addr,
  output logic                              picker_advance,
  output mem_req_t                          req,
  output logic                              req_valid
);

  ctl_state_t state;
  // previous turn was an offer to an idle cpu
  logic last_offer;
  logic do_offer;
  logic do_poll;
  logic take_rw;
  logic msg_seen;

  // offers and polls alternate
  // with nobody running an offer is the only useful turn
  assign do_offer = (state == CPU_LOOP) && any_free && (!last_offer || !any_active);
  assign do_poll = (state == CPU_LOOP) && !do_offer && any_active;
  assign picker_advance = do_poll;

  // memory access takes priority over a message
  assign take_rw = (state == CPU_CMD) && (read_q || write_q);
  assign msg_seen = (state == CPU_CMD) && !take_rw && ext_cpu_e && (cpu_msg_in != MSG_NONE);

  // slot strobes act on the same edge that ends the turn
  always_comb begin
    slot_set = '0;
    slot_clear = '0;
    slot_set_addr = addr_in;
    if (msg_seen) begin
      // start only counts on an offer turn
      if (cpu_msg_in == MSG_START && ext_cpu_index.nonactive && any_free) begin
        slot_set[free_slot] = 1'b1;
      end
      if (cpu_msg_in == MSG_END && ext_cpu_index.active) begin
        slot_clear[ext_cpu_index.num] = slot_active[ext_cpu_index.num];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= RESET_WAIT;
      ext_rst_b <= 1'b1;
      ext_cpu_q <= 1'b0;
      ext_cpu_index <= '0;
      poll_addr <= '0;
      last_offer <= 1'b0;
      req_valid <= 1'b0;
    end else begin
      ext_cpu_q <= 1'b0;
      req_valid <= 1'b0;
      case (state)
        RESET_WAIT: begin
          // release cpus once they report ready
          if (ext_rst_e) begin
            ext_rst_b <= 1'b0;
            state <= CPU_LOOP;
          end
        end
        CPU_LOOP: begin
          if (do_offer) begin
            ext_cpu_q <= 1'b1;
            ext_cpu_index <= '{active: 1'b0, nonactive: 1'b1, num: '0};
            poll_addr <= '0;
            last_offer <= 1'b1;
            state <= CPU_CMD;
          end else if (do_poll) begin
            ext_cpu_q <= 1'b1;
            ext_cpu_index <= '{active: 1'b1, nonactive: 1'b0, num: next_active};
            poll_addr <= slot_addr[next_active];
            last_offer <= 1'b0;
            state <= CPU_CMD;
          end
        end
        CPU_CMD: begin
          // poll address only rides along with the pulse
          poll_addr <= '0;
          if (take_rw) begin
            req_valid <= 1'b1;
            ext_cpu_index <= '0;
            state <= MEM_WORK;
          end else if (ext_cpu_e) begin
            ext_cpu_index <= '0;
            state <= CPU_LOOP;
          end
        end
        MEM_WORK: begin
          if (relay_done || relay_aborted) begin
            state <= CPU_LOOP;
          end
        end
        default: state <= RESET_WAIT;
      endcase
    end
  end

  // request captured as the cpu presents it
  always_ff @(posedge clk) begin
    if (take_rw) begin
      req.read <= read_q;
      req.write <= !read_q;
      req.addr <= addr_in;
      req.data <= data_in;
    end
  end

  // every turn spends at least one cycle in CPU_CMD
  a_cpu_q_one_cycle: assert property (
    @(posedge clk) disable iff (rst)
    ext_cpu_q |=> !ext_cpu_q
  );

endmodule

// File: logic/cpu_dispatcher.sv
`timescale 1ns/1ps

// shares one external memory port among CPU_COUNT cpus
module cpu_dispatcher
  import dispatch_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  // cpu side
  input  logic [ADDR_W-1:0] addr_in,
  input  logic [DATA_W-1:0] data_in,
  input  logic              read_q,
  input  logic              write_q,
  input  logic [MSG_W-1:0]  cpu_msg_in,
  input  logic              ext_cpu_e,
  input  logic              rw_halt,
  output cpu_index_t        ext_cpu_index,
  output logic              ext_cpu_q,
  output logic [ADDR_W-1:0] addr_out,
  output logic [DATA_W-1:0] data_out,
  output logic              read_dn,
  output logic              write_dn,
  output logic              bus_busy,
  // external memory side
  output logic [ADDR_W-1:0] ext_mem_addr_out,
  output logic [DATA_W-1:0] ext_mem_data_out,
  output logic              ext_read_q,
  output logic              ext_write_q,
  output logic              ext_rw_halt,
  input  logic [ADDR_W-1:0] ext_mem_addr_in,
  input  logic [DATA_W-1:0] ext_mem_data_in,
  input  logic              ext_read_dn,
  input  logic              ext_write_dn,
  // cpu reset handshake
  output logic              ext_rst_b,
  input  logic              ext_rst_e
);

  logic [CPU_COUNT-1:0] slot_set;
  logic [CPU_COUNT-1:0] slot_clear;
  logic [ADDR_W-1:0] slot_set_addr;
  logic [CPU_COUNT-1:0] slot_active;
  logic [CPU_COUNT-1:0][ADDR_W-1:0] slot_addr;
  logic [SLOT_W-1:0] free_slot;
  logic any_free;
  logic [SLOT_W-1:0] next_active;
  logic any_active;
  logic picker_advance;
  logic [ADDR_W-1:0] poll_addr;
  mem_req_t req;
  logic req_valid;
  mem_rsp_t rsp;
  logic relay_done;
  logic relay_aborted;

  dispatch_ctl i_dispatch_ctl (
    .clk            (clk),
    .rst            (rst),
    .ext_rst_e      (ext_rst_e),
    .read_q         (read_q),
    .write_q        (write_q),
    .ext_cpu_e      (ext_cpu_e),
    .cpu_msg_in     (cpu_msg_in),
    .addr_in        (addr_in),
    .data_in        (data_in),
    .slot_active    (slot_active),
    .slot_addr      (slot_addr),
    .free_slot      (free_slot),
    .any_free       (any_free),
    .next_active    (next_active),
    .any_active     (any_active),
    .relay_done     (relay_done),
    .relay_aborted  (relay_aborted),
    .ext_rst_b      (ext_rst_b),
    .ext_cpu_q      (ext_cpu_q),
    .ext_cpu_index  (ext_cpu_index),
    .poll_addr      (poll_addr),
    .slot_set       (slot_set),
    .slot_clear     (slot_clear),
    .slot_set_addr  (slot_set_addr),
    .picker_advance (picker_advance),
    .req            (req),
    .req_valid      (req_valid)
  );

  // the cpu table
  for (genvar i = 0; i < CPU_COUNT; i++) begin : g_slot
    cpu_slot i_cpu_slot (
      .clk       (clk),
      .rst       (rst),
      .set       (slot_set[i]),
      .clear     (slot_clear[i]),
      .set_addr  (slot_set_addr),
      .active    (slot_active[i]),
      .proc_addr (slot_addr[i])
    );
  end

  slot_picker i_slot_picker (
    .clk         (clk),
    .rst         (rst),
    .slot_active (slot_active),
    .advance     (picker_advance),
    .free_slot   (free_slot),
    .any_free    (any_free),
    .next_active (next_active),
    .any_active  (any_active)
  );

  mem_relay i_mem_relay (
    .clk              (clk),
    .rst              (rst),
    .req              (req),
    .req_valid        (req_valid),
    .rw_halt          (rw_halt),
    .ext_mem_addr_in  (ext_mem_addr_in),
    .ext_mem_data_in  (ext_mem_data_in),
    .ext_read_dn      (ext_read_dn),
    .ext_write_dn     (ext_write_dn),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q),
    .ext_rw_halt      (ext_rw_halt),
    .ext_mem_addr_out (ext_mem_addr_out),
    .ext_mem_data_out (ext_mem_data_out),
    .rsp              (rsp),
    .read_dn          (read_dn),
    .write_dn         (write_dn),
    .bus_busy         (bus_busy),
    .relay_done       (relay_done),
    .relay_aborted    (relay_aborted)
  );

  // poll address and memory response are never nonzero together
  assign addr_out = poll_addr | rsp.addr;
  assign data_out = rsp.data;

endmodule

// File: bench/dispatch_checker.sv
`timescale 1ns/1ps

// watches the dispatcher ports and grades each vector step
module dispatch_checker
  import dispatch_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  // step context from the vector line
  input  int                step_num,
  input  logic [3:0]        exp_op,
  input  logic [ADDR_W-1:0] cpu_addr,
  input  logic [DATA_W-1:0] cpu_data,
  input  logic [3:0]        exp_index,
  input  logic [ADDR_W-1:0] exp_addr,
  input  logic [DATA_W-1:0] exp_data,
  input  logic              step_end,
  // dut ports
  input  logic              ext_rst_e,
  input  logic              ext_rst_b,
  input  logic              ext_cpu_q,
  input  cpu_index_t        ext_cpu_index,
  input  logic [ADDR_W-1:0] addr_out,
  input  logic [DATA_W-1:0] data_out,
  input  logic              read_dn,
  input  logic              write_dn,
  input  logic              bus_busy,
  input  logic              ext_read_q,
  input  logic              ext_write_q,
  input  logic              ext_rw_halt,
  input  logic [ADDR_W-1:0] ext_mem_addr_out,
  input  logic [DATA_W-1:0] ext_mem_data_out,
  output int                tests_run,
  output int                errors
);

  // op codes of the vector file
  localparam logic [3:0] OP_READ = 4'h3;
  localparam logic [3:0] OP_WRITE = 4'h4;
  localparam logic [3:0] OP_HALT = 4'h5;

  int step_errs;
  logic seen_poll;
  logic seen_done;
  logic seen_halt;
  logic rst_released;
  // ext_rst_b has to be low in the cycle after ext_rst_e
  logic rst_fall_due;

  function automatic string op_name(input logic [3:0] op);
    case (op)
      4'h0: return "none";
      4'h1: return "start";
      4'h2: return "end";
      4'h3: return "read";
      4'h4: return "write";
      4'h5: return "halt";
      default: return "unknown";
    endcase
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail step %0d %s got %h expected %h", step_num, name, got, exp);
      step_errs++;
    end
  endtask

  task automatic complain(input string what);
    $display("step %0d: %s", step_num, what);
    step_errs++;
  endtask

  initial begin
    tests_run = 0;
    errors = 0;
    step_errs = 0;
    seen_poll = 1'b0;
    seen_done = 1'b0;
    seen_halt = 1'b0;
    rst_released = 1'b0;
    rst_fall_due = 1'b0;
  end

  // sampled on the rising edge where every input has settled
  always @(posedge clk) begin
    if (!rst) begin
      // cpus stay in reset until they report ready
      if (!rst_released && ext_rst_b !== 1'b1) begin
        complain("ext_rst_b dropped before ext_rst_e");
      end
      if (rst_fall_due) begin
        rst_fall_due = 1'b0;
        if (ext_rst_b !== 1'b0) begin
          complain("ext_rst_b did not fall after ext_rst_e");
        end
      end
      if (ext_rst_e && !rst_released) begin
        rst_released = 1'b1;
        rst_fall_due = 1'b1;
      end
      if (ext_cpu_q) begin
        seen_poll = 1'b1;
        compare("ext_cpu_index", 32'(ext_cpu_index), 32'(exp_index));
        compare("addr_out", addr_out, exp_addr);
      end
      // cpu side outputs rest at zero between pulses
      if (!ext_cpu_q && !read_dn && !write_dn) begin
        compare("addr_out", addr_out, 32'h0);
      end
      if (!read_dn && !write_dn) begin
        compare("data_out", data_out, 32'h0);
        compare("bus_busy", 32'(bus_busy), 32'h0);
      end
      // request payload on the memory side
      if (ext_read_q && (exp_op == OP_READ || exp_op == OP_HALT)) begin
        compare("ext_mem_addr_out", ext_mem_addr_out, cpu_addr);
      end
      if (ext_write_q) begin
        compare("ext_mem_addr_out", ext_mem_addr_out, cpu_addr);
        compare("ext_mem_data_out", ext_mem_data_out, cpu_data);
      end
      if (read_dn || write_dn) begin
        seen_done = 1'b1;
        if (exp_op == OP_HALT) begin
          complain("done pulse after an aborted request");
        end else begin
          compare("read_dn", 32'(read_dn), 32'(exp_op == OP_READ));
          compare("write_dn", 32'(write_dn), 32'(exp_op == OP_WRITE));
          compare("addr_out", addr_out, cpu_addr);
          compare("data_out", data_out, exp_data);
          compare("bus_busy", 32'(bus_busy), 32'h1);
        end
      end
      if (ext_rw_halt) begin
        seen_halt = 1'b1;
      end
      // step verdict with this cycle's pulses already counted
      if (step_end) begin
        if (!seen_poll) begin
          complain("no ext_cpu_q pulse for this step");
        end
        if ((exp_op == OP_READ || exp_op == OP_WRITE) && !seen_done) begin
          complain("memory access finished without a done pulse");
        end
        if (exp_op == OP_HALT && !seen_halt) begin
          complain("halt gave no ext_rw_halt pulse");
        end
        if (exp_op != OP_HALT && seen_halt) begin
          complain("unexpected ext_rw_halt pulse");
        end
        tests_run++;
        errors += step_errs;
        $display("step %0d %s: %s", step_num, op_name(exp_op), step_errs == 0 ? "ok" : "failed");
        step_errs = 0;
        seen_poll = 1'b0;
        seen_done = 1'b0;
        seen_halt = 1'b0;
      end
    end
  end

endmodule

// File: bench/tb_cpu_dispatcher.sv
`timescale 1ns/1ps

module tb_cpu_dispatcher;
  import dispatch_pkg::*;

  localparam int HALF_PERIOD = 5;
  localparam int RESET_CYCLES = 4;
  localparam int MAX_DELAY = 5;
  localparam int SEED = 32'he2b6ffa4;
  localparam string VECTOR_FILE = "bench/dispatch_vectors.txt";

  logic clk;
  logic rst;
  logic [ADDR_W-1:0] addr_in;
  logic [DATA_W-1:0] data_in;
  logic read_q;
  logic write_q;
  logic [MSG_W-1:0] cpu_msg_in;
  logic ext_cpu_e;
  logic rw_halt;
  cpu_index_t ext_cpu_index;
  logic ext_cpu_q;
  logic [ADDR_W-1:0] addr_out;
  logic [DATA_W-1:0] data_out;
  logic read_dn;
  logic write_dn;
  logic bus_busy;
  logic [ADDR_W-1:0] ext_mem_addr_out;
  logic [DATA_W-1:0] ext_mem_data_out;
  logic ext_read_q;
  logic ext_write_q;
  logic ext_rw_halt;
  logic [ADDR_W-1:0] ext_mem_addr_in;
  logic [DATA_W-1:0] ext_mem_data_in;
  logic ext_read_dn;
  logic ext_write_dn;
  logic ext_rst_b;
  logic ext_rst_e;

  // current step as seen by the checker
  int step_num;
  logic [3:0] exp_op;
  logic [ADDR_W-1:0] cpu_addr;
  logic [DATA_W-1:0] cpu_data;
  logic [3:0] exp_index;
  logic [ADDR_W-1:0] exp_addr;
  logic [DATA_W-1:0] exp_data;
  logic step_end;
  int tests_run;
  int errors;

  // vector table
  logic [3:0] v_op[$];
  logic [31:0] v_addr[$];
  logic [31:0] v_data[$];
  logic [3:0] v_index[$];
  logic [31:0] v_exp_addr[$];
  logic [31:0] v_exp_data[$];

  int cycles;
  int cycle_limit;

  cpu_dispatcher i_cpu_dispatcher (.*);

  dispatch_checker i_dispatch_checker (.*);

  initial clk = 1'b0;
  always #HALF_PERIOD clk = ~clk;

  // run guard with its limit set once the vectors are loaded
  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout after %0d cycles, dispatcher stopped answering", cycles);
      $display("Errors found");
      $finish;
    end
  end

  task automatic load_vectors();
    int fd;
    int n;
    string line;
    logic [31:0] f[6];
    fd = $fopen(VECTOR_FILE, "r");
    if (fd == 0) begin
      $display("cannot open %s", VECTOR_FILE);
      return;
    end
    while ($fgets(line, fd)) begin
      // skip comments and blank lines
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
      if (n == 6) begin
        v_op.push_back(f[0][3:0]);
        v_addr.push_back(f[1]);
        v_data.push_back(f[2]);
        v_index.push_back(f[3][3:0]);
        v_exp_addr.push_back(f[4]);
        v_exp_data.push_back(f[5]);
      end
    end
    $fclose(fd);
  endtask

  // one cpu turn starting on a falling edge
  task automatic run_step(input int i);
    int delay;
    step_num = i;
    exp_op = v_op[i];
    cpu_addr = v_addr[i];
    cpu_data = v_data[i];
    exp_index = v_index[i];
    exp_addr = v_exp_addr[i];
    exp_data = v_exp_data[i];
    while (!ext_cpu_q) @(negedge clk);
    addr_in = cpu_addr;
    // data column of a read is the memory word, the cpu data lines stay idle
    data_in = (exp_op == 4'h4) ? cpu_data : '0;
    if (exp_op <= 4'h2) begin
      // message turn
      ext_cpu_e = 1'b1;
      cpu_msg_in = (exp_op == 4'h1) ? MSG_START : (exp_op == 4'h2) ? MSG_END : MSG_NONE;
      @(negedge clk);
      ext_cpu_e = 1'b0;
      cpu_msg_in = MSG_NONE;
    end else begin
      read_q = (exp_op != 4'h4);
      write_q = (exp_op == 4'h4);
      @(negedge clk);
      read_q = 1'b0;
      write_q = 1'b0;
      while (!(ext_read_q || ext_write_q)) @(negedge clk);
      if (exp_op == 4'h5) begin
        // abort while the memory is still busy
        rw_halt = 1'b1;
        @(negedge clk);
        rw_halt = 1'b0;
        while (!ext_rw_halt) @(negedge clk);
      end else begin
        delay = $urandom_range(MAX_DELAY, 1);
        repeat (delay - 1) @(negedge clk);
        ext_read_dn = ext_read_q;
        ext_write_dn = ext_write_q;
        ext_mem_addr_in = ext_mem_addr_out;
        ext_mem_data_in = (exp_op == 4'h3) ? cpu_data : ext_mem_data_out;
        @(negedge clk);
        ext_read_dn = 1'b0;
        ext_write_dn = 1'b0;
        while (!(read_dn || write_dn)) @(negedge clk);
      end
    end
    step_end = 1'b1;
    @(negedge clk);
    step_end = 1'b0;
  endtask

  initial begin
    int seed_state;
    seed_state = $urandom(SEED);
    cycles = 0;
    cycle_limit = 0;
    rst = 1'b1;
    addr_in = '0;
    data_in = '0;
    read_q = 1'b0;
    write_q = 1'b0;
    cpu_msg_in = MSG_NONE;
    ext_cpu_e = 1'b0;
    rw_halt = 1'b0;
    ext_mem_addr_in = '0;
    ext_mem_data_in = '0;
    ext_read_dn = 1'b0;
    ext_write_dn = 1'b0;
    ext_rst_e = 1'b0;
    step_num = 0;
    exp_op = '0;
    cpu_addr = '0;
    cpu_data = '0;
    exp_index = '0;
    exp_addr = '0;
    exp_data = '0;
    step_end = 1'b0;
    load_vectors();
    cycle_limit = v_op.size() * (5 + MAX_DELAY) + 50;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    repeat (2) @(negedge clk);
    // cpus report ready
    ext_rst_e = 1'b1;
    @(negedge clk);
    ext_rst_e = 1'b0;
    for (int i = 0; i < v_op.size(); i++) begin
      run_step(i);
    end
    @(negedge clk);
    $display("tests %0d, errors %0d", tests_run, errors);
    if (errors == 0 && tests_run == v_op.size() && tests_run > 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: bench/dispatch_vectors.txt
# op(0 none 1 start 2 end 3 read 4 write 5 halt) addr data exp_index exp_addr exp_data
# exp_index 4 is an offer, 8+n polls slot n
1 00001000 00000000 4 00000000 00000000
0 00000000 00000000 8 00001000 00000000
1 00002000 00000000 4 00000000 00000000
0 00000000 00000000 9 00002000 00000000
1 00003000 00000000 4 00000000 00000000
3 00000040 deadbeef a 00003000 deadbeef
0 00000000 00000000 4 00000000 00000000
4 00000080 12345678 8 00001000 12345678
0 00000000 00000000 4 00000000 00000000
5 000000c0 00000000 9 00002000 00000000
0 00000000 00000000 4 00000000 00000000
0 00000000 00000000 a 00003000 00000000
0 00000000 00000000 4 00000000 00000000
0 00000000 00000000 8 00001000 00000000
0 00000000 00000000 4 00000000 00000000
2 00000000 00000000 9 00002000 00000000
0 00000000 00000000 4 00000000 00000000
0 00000000 00000000 a 00003000 00000000
1 00004000 00000000 4 00000000 00000000
0 00000000 00000000 8 00001000 00000000
0 00000000 00000000 4 00000000 00000000
3 00000044 0badf00d 9 00004000 0badf00d

// File: filelist.f
logic/dispatch_pkg.sv
logic/cpu_slot.sv
logic/slot_picker.sv
logic/mem_relay.sv
logic/dispatch_ctl.sv
logic/cpu_dispatcher.sv
bench/dispatch_checker.sv
bench/tb_cpu_dispatcher.sv

// File: Makefile
# Verilator simulation of the cpu dispatcher

VERILATOR ?= verilator
TOP ?= tb_cpu_dispatcher
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass only if '$(PASS_MSG)' is printed"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
